// File: rtl/thread_pkg.sv
package thread_pkg;

    localparam int num_threads = 8;                    // Hardware thread slots

    typedef logic [2:0]             trd_id_t;          // Thread number
    typedef logic [num_threads-1:0] trd_vec_t;         // One flag per thread
    typedef logic [31:0]            pc_t;              // Program counter

    localparam pc_t reset_pc = 32'h0000_1000;          // Thread 0 start address

    // Command kinds broadcast to all slots
    typedef enum logic [2:0] {
        cmd_none   = 3'd0,
        cmd_create = 3'd1,
        cmd_kill   = 3'd2,
        cmd_sleep  = 3'd3,
        cmd_wake   = 3'd4
    } cmd_op_e;

    // One decoded command, 41 bits
    typedef struct packed {
        cmd_op_e op;                                   // What to do
        trd_id_t act;                                  // Thread issuing the command
        trd_id_t obj;                                  // Target slot
        pc_t     pc;                                   // Start pc, create only
    } trd_cmd_t;

    // State held by one slot, 37 bits
    typedef struct packed {
        logic    valid;                                // Slot in use
        logic    running;                              // Not sleeping
        trd_id_t parent;                               // Creator of this thread
        pc_t     pc;                                   // Fetch address
    } slot_state_t;

endpackage

// File: rtl/cmd_decode.sv
`timescale 1ns/1ps

module cmd_decode (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 init_trd,             // Create a new thread
    input  logic                 kill,                 // Kill obj_trd
    input  logic                 slp,                  // Sleep obj_trd
    input  logic                 wake,                 // Wake obj_trd
    input  thread_pkg::trd_id_t  act_trd,              // Thread issuing the command
    input  thread_pkg::trd_id_t  obj_trd,              // Target of kill, sleep, wake
    input  thread_pkg::pc_t      init_pc,              // Start pc for a create
    input  thread_pkg::trd_vec_t valid_trd,            // Slots currently in use
    output thread_pkg::trd_cmd_t cmd,
    output thread_pkg::trd_id_t  new_trd,              // Last allocated thread
    output logic                 trd_of                // Create refused, no free slot
);

    thread_pkg::trd_id_t alloc_id;                     // Lowest free slot above 0
    logic                alloc_ok;                     // A free slot exists

    // Slot 0 is never handed out, search runs from the top so the lowest wins
    always_comb begin
        alloc_id = '0;
        alloc_ok = 1'b0;
        for (int i = thread_pkg::num_threads - 1; i >= 1; i--) begin
            if (!valid_trd[i]) begin
                alloc_id = thread_pkg::trd_id_t'(i);
                alloc_ok = 1'b1;
            end
        end
    end

    // Priority: create, kill, sleep, wake
    always_comb begin
        cmd.op  = thread_pkg::cmd_none;
        cmd.act = act_trd;
        cmd.obj = obj_trd;
        cmd.pc  = init_pc;
        if (init_trd) begin
            if (alloc_ok) begin
                cmd.op  = thread_pkg::cmd_create;
                cmd.obj = alloc_id;                    // Target is the new slot
            end
        end else if (kill) begin
            cmd.op = thread_pkg::cmd_kill;
        end else if (slp) begin
            cmd.op = thread_pkg::cmd_sleep;
        end else if (wake) begin
            cmd.op = thread_pkg::cmd_wake;
        end
    end

    assign trd_of = init_trd & ~alloc_ok;              // Create while all slots taken

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            new_trd <= '0;
        end else if (init_trd && alloc_ok) begin
            new_trd <= alloc_id;
        end
    end

endmodule

// File: rtl/thread_slot.sv
`timescale 1ns/1ps

module thread_slot #(
    parameter int unsigned slot_id = 0                 // Thread number of this slot
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  thread_pkg::trd_cmd_t    cmd,               // Broadcast command
    input  thread_pkg::trd_id_t     cur_trd,           // Thread now fetching
    input  logic                    pc_wr,             // Update pc of cur_trd
    input  thread_pkg::pc_t         nxt_pc,
    output thread_pkg::slot_state_t state,
    output logic                    refused            // Command failed permission check
);

    localparam thread_pkg::trd_id_t my_id = thread_pkg::trd_id_t'(slot_id);

    logic hit;                                         // Command targets this slot
    logic allowed;                                     // Actor may control this slot
    logic ctl_op;                                      // Kill, sleep or wake
    logic do_create;
    logic pc_load;

    assign hit       = (cmd.obj == my_id);
    // Only the thread itself or its parent may touch a live slot
    assign allowed   = state.valid & ((cmd.act == my_id) | (cmd.act == state.parent));
    assign ctl_op    = (cmd.op == thread_pkg::cmd_kill)  |
                       (cmd.op == thread_pkg::cmd_sleep) |
                       (cmd.op == thread_pkg::cmd_wake);
    assign do_create = hit & (cmd.op == thread_pkg::cmd_create);
    assign pc_load   = pc_wr & (cur_trd == my_id);
    assign refused   = hit & ctl_op & ~allowed;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state.valid   <= (slot_id == 0);           // Thread 0 boots running
            state.running <= (slot_id == 0);
            state.parent  <= '0;
            state.pc      <= (slot_id == 0) ? thread_pkg::reset_pc : '0;
        end else if (do_create) begin
            state.valid   <= 1'b1;
            state.running <= 1'b1;
            state.parent  <= cmd.act;
            state.pc      <= cmd.pc;                   // Wins over a pc write
        end else begin
            if (hit && allowed) begin
                case (cmd.op)
                    thread_pkg::cmd_kill: begin
                        state.valid   <= 1'b0;
                        state.running <= 1'b0;
                    end
                    thread_pkg::cmd_sleep: state.running <= 1'b0;
                    thread_pkg::cmd_wake:  state.running <= 1'b1;
                    default: ;
                endcase
            end
            if (pc_load) begin
                state.pc <= nxt_pc;
            end
        end
    end

endmodule

// File: rtl/thread_sched.sv
`timescale 1ns/1ps

module thread_sched (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    stall,             // Hold the thread pointer
    input  thread_pkg::slot_state_t states [thread_pkg::num_threads],
    input  thread_pkg::trd_vec_t    refused,           // Per-slot refusal flags
    output thread_pkg::trd_id_t     cur_trd,           // Thread now fetching
    output thread_pkg::trd_id_t     nxt_trd,           // Thread for the next cycle
    output thread_pkg::trd_vec_t    valid_trd,
    output thread_pkg::trd_vec_t    run_trd,
    output logic                    trd_full,          // Every slot in use
    output logic                    invalid_op,
    output thread_pkg::pc_t         cur_pc
);

    thread_pkg::trd_id_t cand;                         // Candidate in the search

    always_comb begin
        for (int i = 0; i < thread_pkg::num_threads; i++) begin
            valid_trd[i] = states[i].valid;
            run_trd[i]   = states[i].running;
        end
    end

    assign trd_full   = &valid_trd;
    assign invalid_op = |refused;

    // Walk the offsets downward so the nearest running thread after cur_trd wins.
    // With nobody else running the pointer stays put.
    always_comb begin
        nxt_trd = cur_trd;
        cand    = cur_trd;
        for (int k = thread_pkg::num_threads - 1; k >= 1; k--) begin
            cand = cur_trd + thread_pkg::trd_id_t'(k);  // Wraps at 8
            if (run_trd[cand]) begin
                nxt_trd = cand;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_trd <= '0;
        end else if (!stall) begin
            cur_trd <= nxt_trd;
        end
    end

    assign cur_pc = states[cur_trd].pc;                // Fetch address of current thread

endmodule

// File: rtl/thread_ctrl_top.sv
`timescale 1ns/1ps

module thread_ctrl_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stall,                // Hold the thread pointer
    input  logic                 init_trd,             // Create a thread
    input  logic                 kill,
    input  logic                 slp,
    input  logic                 wake,
    input  logic                 pc_wr,                // Write nxt_pc to current thread
    input  thread_pkg::trd_id_t  act_trd,
    input  thread_pkg::trd_id_t  obj_trd,
    input  thread_pkg::pc_t      init_pc,
    input  thread_pkg::pc_t      nxt_pc,
    output thread_pkg::trd_id_t  cur_trd,
    output thread_pkg::trd_id_t  nxt_trd,
    output thread_pkg::trd_id_t  new_trd,
    output thread_pkg::trd_vec_t valid_trd,
    output thread_pkg::trd_vec_t run_trd,
    output logic                 trd_full,
    output logic                 trd_of,
    output logic                 invalid_op,
    output thread_pkg::pc_t      cur_pc
);

    thread_pkg::trd_cmd_t    cmd;                      // Broadcast to every slot
    thread_pkg::slot_state_t slot_states [thread_pkg::num_threads];
    thread_pkg::trd_vec_t    slot_refused;

    cmd_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .init_trd  (init_trd),
        .kill      (kill),
        .slp       (slp),
        .wake      (wake),
        .act_trd   (act_trd),
        .obj_trd   (obj_trd),
        .init_pc   (init_pc),
        .valid_trd (valid_trd),
        .cmd       (cmd),
        .new_trd   (new_trd),
        .trd_of    (trd_of)
    );

    for (genvar i = 0; i < thread_pkg::num_threads; i++) begin : g_slot
        thread_slot #(
            .slot_id (i)
        ) u_slot (
            .clk     (clk),
            .rst_n   (rst_n),
            .cmd     (cmd),
            .cur_trd (cur_trd),
            .pc_wr   (pc_wr),
            .nxt_pc  (nxt_pc),
            .state   (slot_states[i]),
            .refused (slot_refused[i])
        );
    end

    thread_sched u_sched (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .states     (slot_states),
        .refused    (slot_refused),
        .cur_trd    (cur_trd),
        .nxt_trd    (nxt_trd),
        .valid_trd  (valid_trd),
        .run_trd    (run_trd),
        .trd_full   (trd_full),
        .invalid_op (invalid_op),
        .cur_pc     (cur_pc)
    );

endmodule

// File: tb/tb_thread_ctrl.sv
`timescale 1ns/1ps

module tb_thread_ctrl;

    logic                 clk;
    logic                 rst_n;
    logic                 stall;
    logic                 init_trd;
    logic                 kill;
    logic                 slp;
    logic                 wake;
    logic                 pc_wr;
    thread_pkg::trd_id_t  act_trd;
    thread_pkg::trd_id_t  obj_trd;
    thread_pkg::pc_t      init_pc;
    thread_pkg::pc_t      nxt_pc;
    thread_pkg::trd_id_t  cur_trd;
    thread_pkg::trd_id_t  nxt_trd;
    thread_pkg::trd_id_t  new_trd;
    thread_pkg::trd_vec_t valid_trd;
    thread_pkg::trd_vec_t run_trd;
    logic                 trd_full;
    logic                 trd_of;
    logic                 invalid_op;
    thread_pkg::pc_t      cur_pc;

    // Expected thread state
    thread_pkg::trd_vec_t m_valid;
    thread_pkg::trd_vec_t m_run;
    thread_pkg::trd_id_t  m_parent [thread_pkg::num_threads];
    thread_pkg::pc_t      m_pc [thread_pkg::num_threads];
    thread_pkg::trd_id_t  m_cur;                       // Expected current thread
    thread_pkg::trd_id_t  m_new;                       // Expected last allocated thread

    logic [31:0] lfsr_state;
    int          err_count;
    int          timeout_count;

    thread_ctrl_top UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .init_trd   (init_trd),
        .kill       (kill),
        .slp        (slp),
        .wake       (wake),
        .pc_wr      (pc_wr),
        .act_trd    (act_trd),
        .obj_trd    (obj_trd),
        .init_pc    (init_pc),
        .nxt_pc     (nxt_pc),
        .cur_trd    (cur_trd),
        .nxt_trd    (nxt_trd),
        .new_trd    (new_trd),
        .valid_trd  (valid_trd),
        .run_trd    (run_trd),
        .trd_full   (trd_full),
        .trd_of     (trd_of),
        .invalid_op (invalid_op),
        .cur_pc     (cur_pc)
    );

    always #50 clk = ~clk;                             // 100 ns period

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_word(output thread_pkg::pc_t w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[30:0], lfsr_state[0]};              // One step per bit
        end
    endtask

    // First running thread after cur in circular order or cur itself
    function automatic thread_pkg::trd_id_t next_running(input thread_pkg::trd_id_t cur,
                                                         input thread_pkg::trd_vec_t run);
        thread_pkg::trd_id_t c;
        for (int k = 1; k < thread_pkg::num_threads; k++) begin
            c = cur + thread_pkg::trd_id_t'(k);
            if (run[c]) begin
                return c;
            end
        end
        return cur;
    endfunction

    function automatic thread_pkg::trd_id_t lowest_free();
        for (int i = 1; i < thread_pkg::num_threads; i++) begin
            if (!m_valid[i]) begin
                return thread_pkg::trd_id_t'(i);
            end
        end
        return '0;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("ERR %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_state();
        check("valid_trd", 32'(valid_trd), 32'(m_valid));
        check("run_trd", 32'(run_trd), 32'(m_run));
        check("trd_full", 32'(trd_full), 32'(&m_valid));
        check("cur_trd", 32'(cur_trd), 32'(m_cur));
        check("cur_pc", cur_pc, m_pc[m_cur]);
    endtask

    task automatic create_thread(input thread_pkg::trd_id_t act, input thread_pkg::pc_t pc);
        logic                full;
        thread_pkg::trd_id_t slot;
        full     = &m_valid[7:1];                      // Slot 0 is never allocated
        slot     = lowest_free();
        init_trd = 1'b1;
        act_trd  = act;
        init_pc  = pc;
        #20;
        check("trd_of", 32'(trd_of), 32'(full));
        check("invalid_op", 32'(invalid_op), 32'h0);
        @(posedge clk);
        #1;
        init_trd = 1'b0;
        if (!full) begin
            m_valid[slot]  = 1'b1;
            m_run[slot]    = 1'b1;
            m_parent[slot] = act;
            m_pc[slot]     = pc;
            m_new          = slot;
        end
        check_state();
        check("new_trd", 32'(new_trd), 32'(m_new));
    endtask

    task automatic control_cmd(input thread_pkg::cmd_op_e op, input thread_pkg::trd_id_t act,
                               input thread_pkg::trd_id_t obj);
        logic ok;
        // Object must be live and the actor is the object or its parent
        ok      = m_valid[obj] && (act == obj || act == m_parent[obj]);
        kill    = (op == thread_pkg::cmd_kill);
        slp     = (op == thread_pkg::cmd_sleep);
        wake    = (op == thread_pkg::cmd_wake);
        act_trd = act;
        obj_trd = obj;
        #20;
        check("invalid_op", 32'(invalid_op), 32'(!ok));
        check("trd_of", 32'(trd_of), 32'h0);
        @(posedge clk);
        #1;
        kill = 1'b0;
        slp  = 1'b0;
        wake = 1'b0;
        if (ok) begin
            if (op == thread_pkg::cmd_kill) begin
                m_valid[obj] = 1'b0;
                m_run[obj]   = 1'b0;
            end else if (op == thread_pkg::cmd_sleep) begin
                m_run[obj] = 1'b0;
            end else if (op == thread_pkg::cmd_wake) begin
                m_run[obj] = 1'b1;
            end
        end
        check_state();
    endtask

    // Let the scheduler run for n edges and then stall it again
    task automatic run_steps(input int n);
        stall = 1'b0;
        for (int i = 0; i < n; i++) begin
            check("cur_trd", 32'(cur_trd), 32'(m_cur));
            check("cur_pc", cur_pc, m_pc[m_cur]);
            check("nxt_trd", 32'(nxt_trd), 32'(next_running(m_cur, m_run)));
            @(posedge clk);
            #1;
            m_cur = next_running(m_cur, m_run);
        end
        stall = 1'b1;
    endtask

    task automatic wait_for_thread(input thread_pkg::trd_id_t target);
        int n;
        n     = 0;
        stall = 1'b0;
        while (cur_trd != target && n < 20) begin
            @(posedge clk);
            #1;
            m_cur = next_running(m_cur, m_run);
            n++;
        end
        stall = 1'b1;                                  // Hold the pointer on target
        if (cur_trd != target) begin
            timeout_count++;
            $display("Timeout: thread %0d never became the current thread", target);
        end
        check("cur_trd", 32'(cur_trd), 32'(m_cur));
    endtask

    task automatic test_reset_state();
        check("valid_trd", 32'(valid_trd), 32'h01);
        check("run_trd", 32'(run_trd), 32'h01);
        check("cur_trd", 32'(cur_trd), 32'h0);
        check("new_trd", 32'(new_trd), 32'h0);
        check("cur_pc", cur_pc, thread_pkg::reset_pc);
        check("invalid_op", 32'(invalid_op), 32'h0);
        check("trd_of", 32'(trd_of), 32'h0);
    endtask

    task automatic test_allocation();
        thread_pkg::pc_t pc;
        for (int i = 1; i < thread_pkg::num_threads; i++) begin
            rand_word(pc);
            create_thread('0, pc);
            check("new_trd", 32'(new_trd), 32'(i));
            check("valid_trd", 32'(valid_trd), 32'((1 << (i + 1)) - 1));
        end
        check("trd_full", 32'(trd_full), 32'h1);
        rand_word(pc);
        create_thread('0, pc);                         // Eighth create overflows the table
        check("new_trd", 32'(new_trd), 32'h7);
    endtask

    task automatic test_round_robin();
        control_cmd(thread_pkg::cmd_sleep, 3'd0, 3'd2);
        control_cmd(thread_pkg::cmd_sleep, 3'd0, 3'd5);
        run_steps(12);
        repeat (3) begin
            @(posedge clk);
            #1;
            check_state();                             // Pointer frozen by stall
        end
        control_cmd(thread_pkg::cmd_wake, 3'd0, 3'd2);
        control_cmd(thread_pkg::cmd_wake, 3'd0, 3'd5);
    endtask

    task automatic test_permissions();
        control_cmd(thread_pkg::cmd_sleep, 3'd0, 3'd3);
        run_steps(10);
        control_cmd(thread_pkg::cmd_wake, 3'd0, 3'd3);
        control_cmd(thread_pkg::cmd_kill, 3'd1, 3'd4); // Sibling has no rights over it
        control_cmd(thread_pkg::cmd_sleep, 3'd2, 3'd0); // Child acting on its parent
        control_cmd(thread_pkg::cmd_kill, 3'd6, 3'd6);
        control_cmd(thread_pkg::cmd_wake, 3'd0, 3'd6); // Slot already freed
    endtask

    task automatic test_pc_write();
        thread_pkg::pc_t pc;
        wait_for_thread(3'd4);
        rand_word(pc);
        nxt_pc = pc;
        pc_wr  = 1'b1;
        @(posedge clk);
        #1;
        pc_wr    = 1'b0;
        m_pc[4] = pc;
        check("cur_trd", 32'(cur_trd), 32'h4);
        check("cur_pc", cur_pc, pc);
        rand_word(pc);
        create_thread(3'd4, pc);
        check("new_trd", 32'(new_trd), 32'h6);         // Lowest freed slot reused
        control_cmd(thread_pkg::cmd_kill, 3'd0, 3'd6); // Thread 4 is the parent now
        control_cmd(thread_pkg::cmd_sleep, 3'd4, 3'd6);
        run_steps(9);
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        stall         = 1'b1;
        init_trd      = 1'b0;
        kill          = 1'b0;
        slp           = 1'b0;
        wake          = 1'b0;
        pc_wr         = 1'b0;
        act_trd       = '0;
        obj_trd       = '0;
        init_pc       = '0;
        nxt_pc        = '0;
        lfsr_state    = 32'h5cd57b7c;
        err_count     = 0;
        timeout_count = 0;
        m_valid       = 8'h01;
        m_run         = 8'h01;
        m_cur         = '0;
        m_new         = '0;
        for (int i = 0; i < thread_pkg::num_threads; i++) begin
            m_parent[i] = '0;
            m_pc[i]     = '0;
        end
        m_pc[0] = thread_pkg::reset_pc;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset_state();
        test_allocation();
        test_round_robin();
        test_permissions();
        test_pc_write();
        $display("Errors: %0d, timeouts: %0d", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
rtl/thread_pkg.sv
rtl/cmd_decode.sv
rtl/thread_slot.sv
rtl/thread_sched.sv
rtl/thread_ctrl_top.sv
tb/tb_thread_ctrl.sv

// File: Makefile
TOP = tb_thread_ctrl

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f all.f --top-module thread_ctrl_top

sim:
	verilator --binary --timing -f all.f --top-module $(TOP) --Mdir obj_dir -o sim_$(TOP)
	@out=$$(./obj_dir/sim_$(TOP)); echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
